// ==== project.f ====
+incdir+bench
hw/tcdm_pkg.sv
hw/tcdm_arbiter_2x1.sv
hw/tcdm_bank_demux.sv
hw/tcdm_bank.sv
hw/tcdm_cluster_mem_top.sv
bench/tb_tcdm_cluster_mem.sv

// ==== bench/tb_tcdm_ref.svh ====
`ifndef TB_TCDM_REF_SVH
`define TB_TCDM_REF_SVH

// Shadow of both banks, indexed by word address
localparam int unsigned TOTAL_WORDS = N_BANKS * BANK_WORDS;
localparam int unsigned IDX_W       = $clog2(TOTAL_WORDS);

logic [DATA_W-1:0] shadow_mem [TOTAL_WORDS];
int unsigned       err_cnt   = 0;
int unsigned       check_cnt = 0;

// Bank select bit is the low bit of the word index, the six row bits follow
function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
    return addr[BANK_SEL_BIT +: IDX_W];
endfunction

// Initial contents, every address bit takes part
function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] word;
    word = {~addr[15:0], addr[15:0]} ^ {addr[31:16], addr[31:16]};
    return word ^ 32'h5A3C_96E1;
endfunction

// Stored word merged with wdata under be
// With be all zero this is the word a read must return
function automatic logic [DATA_W-1:0] expect_word(
    input logic [ADDR_W-1:0] addr,
    input logic [DATA_W-1:0] wdata,
    input logic [BE_W-1:0]   be
);
    logic [DATA_W-1:0] word;
    int                i;
    word = shadow_mem[word_index(addr)];
    for (i = 0; i < BE_W; i++) begin
        if (be[i]) begin
            word[i*8 +: 8] = wdata[i*8 +: 8];
        end
    end
    return word;
endfunction

task automatic check_value(
    input string             name,
    input logic [DATA_W-1:0] exp_val,
    input logic [DATA_W-1:0] got_val
);
    check_cnt++;
    if (got_val !== exp_val) begin
        err_cnt++;
        $display("ERROR %s exp 0x%08h got 0x%08h", name, exp_val, got_val);
    end
endtask

`endif

// ==== bench/tb_tcdm_cluster_mem.sv ====
`timescale 1ns/1ps

module tb_tcdm_cluster_mem import tcdm_pkg::*; ();

    `include "tb_tcdm_ref.svh"

    localparam int unsigned N_RAND = 300;

    // Accesses per master over test 1, test 2, tests 3 to 6 and random traffic
    localparam int unsigned ACCESS_CNT = TOTAL_WORDS + 48 + 16 + N_RAND;
    // Twice the worst case of four cycles per colliding access plus reset and sleep
    localparam int unsigned MAX_CYCLES = 2 * 4 * ACCESS_CNT + 64;

    logic               clk_i;
    logic               rst_ni;
    logic [N_BANKS-1:0] sleep;
    tcdm_req_t          mst_req [N_MASTERS];
    tcdm_rsp_t          mst_rsp [N_MASTERS];

    int unsigned cycle_cnt = 0;
    int          seed      = 87781;

    // Per master transaction state for drivers and the compare process
    logic              pend       [N_MASTERS];
    logic              pend_rd    [N_MASTERS];
    logic [DATA_W-1:0] exp_rdata  [N_MASTERS];
    logic [DATA_W-1:0] last_rdata [N_MASTERS];
    int unsigned       gnt_cycle  [N_MASTERS];
    int unsigned       rv_cycle   [N_MASTERS];
    int unsigned       grant_order [$];

    tcdm_cluster_mem_top DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .sleep_i   (sleep),
        .mst_req_i (mst_req),
        .mst_rsp_o (mst_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Cycle counter and timeout
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // One TCDM transaction that starts and ends 10 ns after a rising edge
    task automatic run_access(
        input int                m,
        input logic [ADDR_W-1:0] addr,
        input logic              wen,     // High for a read
        input logic [DATA_W-1:0] wdata,
        input logic [BE_W-1:0]   be
    );
        mst_req[m].add   = addr;
        mst_req[m].wen   = wen;
        mst_req[m].wdata = wdata;
        mst_req[m].be    = be;
        mst_req[m].req   = 1'b1;
        do @(negedge clk_i); while (!mst_rsp[m].gnt);   // Request held until granted
        gnt_cycle[m] = cycle_cnt;
        grant_order.push_back(m);
        if (wen) begin
            exp_rdata[m] = expect_word(addr, '0, '0);
        end else begin
            shadow_mem[word_index(addr)] = expect_word(addr, wdata, be);
        end
        pend_rd[m] = wen;
        pend[m]    = 1'b1;
        @(posedge clk_i);
        #10;
        mst_req[m].req = 1'b0;
        do @(negedge clk_i); while (!mst_rsp[m].r_valid);
        @(posedge clk_i);
        #10;
    endtask

    // Compare every response against the reference
    always @(negedge clk_i) begin
        for (int m = 0; m < N_MASTERS; m++) begin
            if (rst_ni === 1'b1 && mst_rsp[m].r_valid === 1'b1) begin
                if (pend[m] !== 1'b1) begin
                    err_cnt++;
                    $display("Master %0d got r_valid with no transaction pending", m);
                end else begin
                    rv_cycle[m] = cycle_cnt;
                    check_value($sformatf("mst_rsp_o[%0d] r_valid latency", m),
                                1, cycle_cnt - gnt_cycle[m]);
                    if (pend_rd[m]) begin
                        check_value($sformatf("mst_rsp_o[%0d].r_rdata", m),
                                    exp_rdata[m], mst_rsp[m].r_rdata);
                    end
                    last_rdata[m] = mst_rsp[m].r_rdata;
                    pend[m]       = 1'b0;
                end
            end
        end
    end

    task automatic report_test(input string name, input int unsigned err_start);
        if (err_cnt == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        int unsigned       err_start;
        int unsigned       wake_cycle;
        logic [ADDR_W-1:0] r_addr  [N_MASTERS];
        logic              r_wen   [N_MASTERS];
        logic [DATA_W-1:0] r_wdata [N_MASTERS];
        logic [BE_W-1:0]   r_be    [N_MASTERS];

        rst_ni = 1'b0;
        sleep  = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            mst_req[m] = '0;
            pend[m]    = 1'b0;
            pend_rd[m] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;

        // Idle after reset
        @(negedge clk_i);
        for (int m = 0; m < N_MASTERS; m++) begin
            check_value($sformatf("mst_rsp_o[%0d].gnt", m), 0, mst_rsp[m].gnt);
            check_value($sformatf("mst_rsp_o[%0d].r_valid", m), 0, mst_rsp[m].r_valid);
        end
        @(posedge clk_i);
        #10;

        // Test 1 fills the whole memory and then reads it back
        err_start = err_cnt;
        fork
            for (int w = 0; w < BANK_WORDS; w++)
                run_access(0, ADDR_W'(w * 4), 1'b0, fill_word(ADDR_W'(w * 4)), '1);
            for (int w = BANK_WORDS; w < TOTAL_WORDS; w++)
                run_access(1, ADDR_W'(w * 4), 1'b0, fill_word(ADDR_W'(w * 4)), '1);
        join
        fork
            for (int w = 0; w < BANK_WORDS; w++)
                run_access(0, ADDR_W'(w * 4), 1'b1, '0, '0);
            for (int w = BANK_WORDS; w < TOTAL_WORDS; w++)
                run_access(1, ADDR_W'(w * 4), 1'b1, '0, '0);
        join
        report_test("1 read-back", err_start);

        // Test 2 writes every be pattern over a known word
        err_start = err_cnt;
        for (int p = 0; p < 16; p++) begin
            run_access(p % 2, 32'h80, 1'b0, 32'h0123_4567, 4'hF);
            run_access(p % 2, 32'h80, 1'b0, 32'hA0B0_C0D0 | {8{4'(p)}}, 4'(p));
            run_access(p % 2, 32'h80, 1'b1, '0, '0);
        end
        report_test("2 byte enables", err_start);

        // Test 3 shows that neighbouring words sit in different banks
        err_start = err_cnt;
        run_access(0, 32'h40, 1'b0, 32'h1111_AAAA, '1);
        run_access(0, 32'h44, 1'b0, 32'h2222_BBBB, '1);
        run_access(1, 32'h40, 1'b1, '0, '0);
        check_value("mst_rsp_o[1].r_rdata at 0x40", 32'h1111_AAAA, last_rdata[1]);
        run_access(1, 32'h44, 1'b1, '0, '0);
        check_value("mst_rsp_o[1].r_rdata at 0x44", 32'h2222_BBBB, last_rdata[1]);
        report_test("3 interleaving", err_start);

        // Test 4 puts both masters on bank 0 in the same cycle
        err_start = err_cnt;
        grant_order.delete();
        fork
            run_access(0, 32'h10, 1'b1, '0, '0);
            run_access(1, 32'h18, 1'b0, 32'hCAFE_0018, '1);
        join
        check_value("grant_order[0]", 0, grant_order[0]);
        check_value("mst_rsp_o[1].gnt cycle", rv_cycle[0] + 1, gnt_cycle[1]);
        run_access(0, 32'h18, 1'b1, '0, '0);
        report_test("4 same-bank conflict", err_start);

        // Test 5 lets different banks proceed together
        err_start = err_cnt;
        fork
            run_access(0, 32'h20, 1'b1, '0, '0);
            run_access(1, 32'h24, 1'b1, '0, '0);
        join
        check_value("mst_rsp_o[1].gnt cycle on reads", gnt_cycle[0], gnt_cycle[1]);
        fork
            run_access(0, 32'h28, 1'b0, 32'h0BAD_F00D, '1);
            run_access(1, 32'h2C, 1'b0, 32'hFEED_BEEF, '1);
        join
        check_value("mst_rsp_o[1].gnt cycle on writes", gnt_cycle[0], gnt_cycle[1]);
        report_test("5 parallel banks", err_start);

        // Test 6 puts bank 1 to sleep while master 0 waits and bank 0 stays usable
        err_start = err_cnt;
        sleep[1]   = 1'b1;
        wake_cycle = 0;
        fork
            run_access(0, 32'h104, 1'b1, '0, '0);
            begin
                repeat (5) begin
                    @(negedge clk_i);
                    check_value("mst_rsp_o[0].gnt while asleep", 0, mst_rsp[0].gnt);
                end
                @(posedge clk_i);
                #10;
                sleep      = '0;
                wake_cycle = cycle_cnt;
            end
            run_access(1, 32'h100, 1'b0, 32'h5EE9_0100, '1);
        join
        check_value("mst_rsp_o[0].gnt cycle after wake", wake_cycle, gnt_cycle[0]);

        // Lock step random traffic makes collisions frequent
        for (int i = 0; i < N_RAND; i++) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                r_addr[m]  = $random(seed) & 32'h1FC;
                r_wen[m]   = $random(seed);
                r_wdata[m] = $random(seed);
                r_be[m]    = $random(seed);
            end
            fork
                run_access(0, r_addr[0], r_wen[0], r_wdata[0], r_be[0]);
                run_access(1, r_addr[1], r_wen[1], r_wdata[1], r_be[1]);
            join
        end
        report_test("6 sleep and random traffic", err_start);

        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/tcdm_cluster_mem_top.sv ====
`timescale 1ns/1ps

module tcdm_cluster_mem_top import tcdm_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic [N_BANKS-1:0] sleep_i,

    // One TCDM port per master
    input  tcdm_req_t          mst_req_i [N_MASTERS],
    output tcdm_rsp_t          mst_rsp_o [N_MASTERS]
);

    // Crossbar wires, indexed [master][bank]
    tcdm_req_t xbar_req [N_MASTERS][N_BANKS];
    tcdm_rsp_t xbar_rsp [N_MASTERS][N_BANKS];

    // Arbiter to bank
    tcdm_req_t bank_req [N_BANKS];
    tcdm_rsp_t bank_rsp [N_BANKS];

    // Address decode per master
    for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
        tcdm_bank_demux i_demux (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .mst_req_i  (mst_req_i[m]),
            .mst_rsp_o  (mst_rsp_o[m]),
            .bank_req_o (xbar_req[m]),
            .bank_rsp_i (xbar_rsp[m])
        );
    end

    // Arbiter and SRAM per bank
    // Master 0 always sits on the priority port
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        tcdm_arbiter_2x1 i_arbiter (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_0_i (xbar_req[0][b]),
            .rsp_0_o (xbar_rsp[0][b]),
            .req_1_i (xbar_req[1][b]),
            .rsp_1_o (xbar_rsp[1][b]),
            .req_o   (bank_req[b]),
            .rsp_i   (bank_rsp[b])
        );

        tcdm_bank i_bank (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .sleep_i (sleep_i[b]),
            .req_i   (bank_req[b]),
            .rsp_o   (bank_rsp[b])
        );
    end

endmodule

// ==== hw/tcdm_bank.sv ====
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      sleep_i,   // Blocks all grants while high

    input  tcdm_req_t req_i,
    output tcdm_rsp_t rsp_o
);

    logic [DATA_W-1:0] mem_q [BANK_WORDS];

    row_t              row;
    logic              gnt;
    logic              wr_en;
    logic              rd_en;
    logic              r_valid_q;
    logic [DATA_W-1:0] rdata_q;

    // Row index above the bank select bits
    assign row = req_i.add[ROW_LSB +: ROW_W];

    // Single port, always ready unless asleep
    assign gnt   = req_i.req & ~sleep_i;
    assign wr_en = gnt & ~req_i.wen;
    assign rd_en = gnt & req_i.wen;

    // Byte-lane writes at the grant edge
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int unsigned i = 0; i < BE_W; i++) begin
                if (req_i.be[i]) begin
                    mem_q[row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Full word read, one cycle latency
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= mem_q[row];
        end
    end

    // One response per grant, reads and writes alike
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= gnt;
        end
    end

    always_comb begin
        rsp_o.gnt     = gnt;
        rsp_o.r_valid = r_valid_q;
        rsp_o.r_rdata = rdata_q;
    end

endmodule

// ==== hw/tcdm_bank_demux.sv ====
`timescale 1ns/1ps

module tcdm_bank_demux import tcdm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    // Master side
    input  tcdm_req_t mst_req_i,
    output tcdm_rsp_t mst_rsp_o,

    // One port per bank
    output tcdm_req_t bank_req_o [N_BANKS],
    input  tcdm_rsp_t bank_rsp_i [N_BANKS]
);

    bank_idx_t sel;      // Bank addressed by the current request
    bank_idx_t bank_q;   // Bank that owes the response
    logic      pend_q;   // Granted, waiting for r_valid
    logic      gnt;
    logic      r_valid;

    // Interleaving on the word address
    assign sel = mst_req_i.add[BANK_SEL_BIT +: BANK_IDX_W];

    // Request path is purely combinational
    always_comb begin
        for (int unsigned b = 0; b < N_BANKS; b++) begin
            bank_req_o[b]     = mst_req_i;  // Payload fans out to all banks
            bank_req_o[b].req = mst_req_i.req && (sel == bank_idx_t'(b));
        end
    end

    // Grant comes from the addressed bank in the same cycle
    assign gnt = mst_req_i.req & bank_rsp_i[sel].gnt;

    // Response comes from the bank that granted, not from the current address
    assign r_valid = pend_q & bank_rsp_i[bank_q].r_valid;

    always_comb begin
        mst_rsp_o.gnt     = gnt;
        mst_rsp_o.r_valid = r_valid;
        mst_rsp_o.r_rdata = bank_rsp_i[bank_q].r_rdata;
    end

    // Remember the target bank from grant until response
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= 1'b0;
            bank_q <= '0;
        end else if (gnt) begin
            pend_q <= 1'b1;
            bank_q <= sel;
        end else if (r_valid) begin
            pend_q <= 1'b0;   // Transaction done
        end
    end

endmodule

// ==== hw/tcdm_arbiter_2x1.sv ====
`timescale 1ns/1ps

module tcdm_arbiter_2x1 import tcdm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    // Master side, port 0 has priority
    input  tcdm_req_t req_0_i,
    output tcdm_rsp_t rsp_0_o,
    input  tcdm_req_t req_1_i,
    output tcdm_rsp_t rsp_1_o,

    // Bank side
    output tcdm_req_t req_o,
    input  tcdm_rsp_t rsp_i
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT_0,
        WAIT_GNT_1,
        WAIT_VALID_0,
        WAIT_VALID_1
    } arb_state_e;

    arb_state_e state_q, state_d;

    logic sel_1;      // Port 1 drives the bank this cycle
    logic rvalid_en;  // A transaction is owned, so r_valid may pass

    // Next state and owner select
    always_comb begin
        state_d   = state_q;
        sel_1     = 1'b0;
        rvalid_en = 1'b0;

        unique case (state_q)
            IDLE: begin
                // Fixed priority, decided in the same cycle
                if (req_0_i.req) begin
                    state_d = rsp_i.gnt ? WAIT_VALID_0 : WAIT_GNT_0;
                end else if (req_1_i.req) begin
                    sel_1   = 1'b1;
                    state_d = rsp_i.gnt ? WAIT_VALID_1 : WAIT_GNT_1;
                end
            end

            WAIT_GNT_0: begin
                rvalid_en = 1'b1;
                if (rsp_i.gnt) begin
                    state_d = WAIT_VALID_0;
                end
            end

            WAIT_GNT_1: begin
                sel_1     = 1'b1;
                rvalid_en = 1'b1;
                if (rsp_i.gnt) begin
                    state_d = WAIT_VALID_1;
                end
            end

            // Owner keeps the bank until its response is out
            WAIT_VALID_0: begin
                rvalid_en = 1'b1;
                if (rsp_i.r_valid) begin
                    state_d = IDLE;
                end
            end

            WAIT_VALID_1: begin
                sel_1     = 1'b1;
                rvalid_en = 1'b1;
                if (rsp_i.r_valid) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Whole request of the owner goes to the bank
    // In IDLE without requests port 0 is forwarded with req low
    assign req_o = sel_1 ? req_1_i : req_0_i;

    always_comb begin
        // Read data is broadcast, only the owner sees r_valid
        rsp_0_o.r_rdata = rsp_i.r_rdata;
        rsp_1_o.r_rdata = rsp_i.r_rdata;

        rsp_0_o.gnt = rsp_i.gnt & ~sel_1;
        rsp_1_o.gnt = rsp_i.gnt & sel_1;

        rsp_0_o.r_valid = rsp_i.r_valid & rvalid_en & ~sel_1;
        rsp_1_o.r_valid = rsp_i.r_valid & rvalid_en & sel_1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hw/tcdm_pkg.sv ====
package tcdm_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // Memory geometry
    localparam int unsigned N_MASTERS    = 2;
    localparam int unsigned N_BANKS      = 2;
    localparam int unsigned BANK_WORDS   = 64;
    localparam int unsigned BANK_SEL_BIT = 2;                      // Word interleaving

    localparam int unsigned BANK_IDX_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
    localparam int unsigned ROW_W      = $clog2(BANK_WORDS);
    localparam int unsigned ROW_LSB    = BANK_SEL_BIT + BANK_IDX_W; // Row bits sit above bank bits

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [ROW_W-1:0]      row_t;

    // Request towards the banks
    // wen is active low, so a low wen is a write
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] add;
        logic              wen;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } tcdm_req_t;

    // Response back to the masters
    typedef struct packed {
        logic              gnt;
        logic              r_valid;
        logic [DATA_W-1:0] r_rdata;
    } tcdm_rsp_t;

endpackage
